// File: source/debug_pkg.sv
package debug_pkg;

    localparam int xlen = 32;
    localparam int gpr_count = 32;

    localparam logic [7:0] cmdtype_access_reg = 8'd0;

    typedef logic [15:0] regno_t;

    localparam regno_t gpr_first = 16'h1000;
    localparam regno_t gpr_last  = 16'h101F;
    localparam regno_t csr_dcsr  = 16'h07B0;
    localparam regno_t csr_dpc   = 16'h07B1;

    localparam int dcsr_step_bit    = 2;
    localparam int dcsr_cause_lsb   = 6;
    localparam int dcsr_cause_msb   = 8;
    localparam int dcsr_ebreakm_bit = 15;

    // Debug spec version 4 sits in the top nibble.
    localparam logic [xlen-1:0] dcsr_reset_val = 32'h4000_0000;
    localparam logic [xlen-1:0] gpr_reset_step = 32'h0101_0101;
    localparam logic [xlen-1:0] pc_incr        = 32'd4;

    typedef enum logic [1:0] {
        st_run,
        st_halted,
        st_resuming,
        st_abs_reg
    } seq_state_t;

    typedef enum logic [2:0] {
        cause_none    = 3'd0,
        cause_ebreak  = 3'd1,
        cause_trigger = 3'd2,
        cause_haltreq = 3'd3,
        cause_step    = 3'd4
    } cause_t;

    typedef struct packed {
        logic [7:0] cmdtype;
        logic       transfer;
        logic       write;
        regno_t     regno;
    } cmd_t;

    typedef struct packed {
        logic            halt_req;
        logic            resume_req;
        logic            exec;
        cmd_t            command;
        logic [xlen-1:0] data;
    } dm_req_t;

    typedef struct packed {
        logic            halted;
        logic            done;
        logic            exception;
        logic            haltresume;
        logic [xlen-1:0] data;
    } dm_rsp_t;

    typedef struct packed {
        seq_state_t state;
        logic       write_pc;
        logic       write_pc_ne;
        logic       abstract_done;
        logic       abstract_write;
    } ctrl_sig_t;

    typedef struct packed {
        logic [xlen-1:0] dcsr;
        logic [xlen-1:0] dpc;
    } csr_view_t;

    function automatic logic is_gpr(input regno_t regno);
        return (regno >= gpr_first) && (regno <= gpr_last);
    endfunction

    function automatic logic is_valid_csr(input regno_t regno);
        return (regno == csr_dcsr) || (regno == csr_dpc);
    endfunction

endpackage

// File: source/d_ctl.sv
`timescale 1ns/1ps

module d_ctl import debug_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,

    input  logic            eb,
    input  logic            trig,

    input  logic [xlen-1:0] pc_reg,
    input  logic [xlen-1:0] pc_next,

    input  ctrl_sig_t       ctrl,
    input  csr_view_t       csrs,
    input  dm_req_t         dm_req,

    output logic            debug,
    output logic            halted,
    output logic            step_en,
    output logic            reg_error,
    output logic            done,
    output cause_t          dcsr_cause,
    output logic [xlen-1:0] dpc_in,
    output logic            dpc_write
);

    logic   running;
    logic   ctrl_halted;
    logic   ctrl_resuming;
    logic   ctrl_abs;
    logic   ebreak;
    logic   instruction_end;

    logic   trigger_cause;
    logic   ebreak_cause;
    logic   halt_cause;
    logic   step_cause;
    logic   halt_any;

    logic   debug_reg;
    logic   halted_reg;
    cause_t cause_reg;
    cause_t cause_next;
    logic   aar;

    assign running       = ctrl.state == st_run;
    assign ctrl_halted   = ctrl.state == st_halted;
    assign ctrl_resuming = ctrl.state == st_resuming;
    assign ctrl_abs      = ctrl.state == st_abs_reg;

    // An instruction only retires while the sequencer is running.
    assign instruction_end = ctrl.write_pc;
    assign ebreak          = eb && ctrl.write_pc;

    assign trigger_cause = trig && running;
    assign ebreak_cause  = ebreak && csrs.dcsr[dcsr_ebreakm_bit];
    assign halt_cause    = dm_req.halt_req && running;
    assign step_cause    = step_en && instruction_end;
    assign halt_any      = trigger_cause || ebreak_cause || halt_cause || step_cause;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            debug_reg  <= 1'b0;
            halted_reg <= 1'b0;
        end else begin
            debug_reg  <= debug;
            halted_reg <= halted;
        end
    end

    // Debug follows the causes in the same cycle so DPC can be captured at once.
    assign debug  = (debug_reg || halt_any) && !dm_req.resume_req;
    assign halted = (halted_reg || (debug_reg && ctrl_halted)) && !ctrl_resuming;

    assign step_en   = csrs.dcsr[dcsr_step_bit];
    assign dpc_write = debug && !debug_reg;
    assign done      = ctrl.abstract_done;

    always_comb begin
        if (trigger_cause) begin
            cause_next = cause_trigger;
        end else if (ebreak_cause) begin
            cause_next = cause_ebreak;
        end else if (halt_cause) begin
            cause_next = cause_haltreq;
        end else if (step_cause) begin
            cause_next = cause_step;
        end else begin
            cause_next = cause_none;
        end
    end

    // A halt request lands after the current instruction unless that one is an ebreak.
    always_comb begin
        if (trigger_cause || ebreak_cause) begin
            dpc_in = pc_reg;
        end else if (halt_cause) begin
            dpc_in = ctrl.write_pc_ne ? pc_next : pc_reg;
        end else if (step_cause) begin
            dpc_in = pc_next;
        end else begin
            dpc_in = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cause_reg <= cause_none;
        end else if (dpc_write) begin
            cause_reg <= cause_next;
        end
    end

    assign dcsr_cause = cause_reg;

    assign aar = dm_req.command.cmdtype == cmdtype_access_reg;

    assign reg_error = aar && ctrl_abs && dm_req.command.transfer
                       && !(is_gpr(dm_req.command.regno)
                            || is_valid_csr(dm_req.command.regno));

endmodule

// File: source/debug_csrs.sv
`timescale 1ns/1ps

module debug_csrs import debug_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,

    input  cause_t          dcsr_cause,
    input  logic [xlen-1:0] dpc_in,
    input  logic            dpc_write,

    input  logic            abs_csr_write,
    input  regno_t          abs_regno,
    input  logic [xlen-1:0] abs_data,

    output csr_view_t       csrs
);

    logic            step_reg;
    logic            ebreakm_reg;
    logic [xlen-1:0] dpc_reg;
    logic            dcsr_sel;
    logic            dpc_sel;

    assign dcsr_sel = abs_csr_write && (abs_regno == csr_dcsr);
    assign dpc_sel  = abs_csr_write && (abs_regno == csr_dpc);

    // Only step and ebreakm are writable by the host.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step_reg    <= 1'b0;
            ebreakm_reg <= 1'b0;
        end else if (dcsr_sel) begin
            step_reg    <= abs_data[dcsr_step_bit];
            ebreakm_reg <= abs_data[dcsr_ebreakm_bit];
        end
    end

    // Hardware capture on debug entry wins over a host write.
    always_ff @(posedge clk) begin
        if (dpc_write) begin
            dpc_reg <= dpc_in;
        end else if (dpc_sel) begin
            dpc_reg <= abs_data;
        end
    end

    always_comb begin
        csrs.dcsr                                 = dcsr_reset_val;
        csrs.dcsr[dcsr_step_bit]                  = step_reg;
        csrs.dcsr[dcsr_ebreakm_bit]               = ebreakm_reg;
        csrs.dcsr[dcsr_cause_msb:dcsr_cause_lsb]  = dcsr_cause;
        csrs.dpc                                  = dpc_reg;
    end

endmodule

// File: source/core_ctl_seq.sv
`timescale 1ns/1ps

module core_ctl_seq import debug_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,

    input  logic            eb,
    input  logic            debug,
    input  dm_req_t         dm_req,
    input  logic            reg_error,
    input  csr_view_t       csrs,

    output ctrl_sig_t       ctrl,
    output logic [xlen-1:0] pc_reg,
    output logic [xlen-1:0] pc_next,
    output logic            abs_csr_write,
    output regno_t          abs_regno,
    output logic [xlen-1:0] abs_data,
    output logic [xlen-1:0] rd_data
);

    seq_state_t      state;
    logic [xlen-1:0] gpr [gpr_count];
    logic            cmd_is_gpr;
    logic [4:0]      gpr_idx;
    logic            xfer_ok;

    assign cmd_is_gpr = is_gpr(dm_req.command.regno);
    assign gpr_idx    = dm_req.command.regno[4:0];

    assign ctrl.state          = state;
    assign ctrl.write_pc       = state == st_run;
    assign ctrl.write_pc_ne    = ctrl.write_pc && !eb;
    assign ctrl.abstract_done  = state == st_abs_reg;
    assign ctrl.abstract_write = ctrl.abstract_done
                                 && (dm_req.command.cmdtype == cmdtype_access_reg)
                                 && dm_req.command.transfer && dm_req.command.write;

    // The host keeps command and data stable until done.
    assign xfer_ok       = ctrl.abstract_write && !reg_error;
    assign abs_csr_write = xfer_ok && !cmd_is_gpr;
    assign abs_regno     = dm_req.command.regno;
    assign abs_data      = dm_req.data;

    assign pc_next = pc_reg + pc_incr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= st_run;
            pc_reg <= '0;
        end else begin
            case (state)
                st_run: begin
                    if (debug) begin
                        state <= st_halted;
                    end else begin
                        pc_reg <= pc_next;
                    end
                end
                st_halted: begin
                    if (dm_req.resume_req) begin
                        state <= st_resuming;
                    end else if (dm_req.exec) begin
                        state <= st_abs_reg;
                    end
                end
                st_abs_reg: begin
                    state <= st_halted;
                end
                default: begin
                    // Execution restarts from the saved DPC.
                    pc_reg <= csrs.dpc;
                    state  <= st_run;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < gpr_count; i++) begin
                gpr[i] <= xlen'(i) * gpr_reset_step;
            end
        end else if (xfer_ok && cmd_is_gpr && (gpr_idx != 5'd0)) begin
            gpr[gpr_idx] <= dm_req.data;
        end
    end

    always_comb begin
        if (cmd_is_gpr) begin
            rd_data = (gpr_idx == 5'd0) ? '0 : gpr[gpr_idx];
        end else if (dm_req.command.regno == csr_dcsr) begin
            rd_data = csrs.dcsr;
        end else if (dm_req.command.regno == csr_dpc) begin
            rd_data = csrs.dpc;
        end else begin
            rd_data = '0;
        end
    end

endmodule

// File: source/debug_top.sv
`timescale 1ns/1ps

module debug_top import debug_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  dm_req_t         dm_req,
    input  logic            trig,
    input  logic            eb,

    output dm_rsp_t         dm_rsp,
    output logic            debug,
    output logic            halted,
    output logic            step_en,
    output logic [xlen-1:0] pc
);

    ctrl_sig_t       ctrl;
    csr_view_t       csrs;
    logic [xlen-1:0] pc_reg;
    logic [xlen-1:0] pc_next;
    cause_t          dcsr_cause;
    logic [xlen-1:0] dpc_in;
    logic            dpc_write;
    logic            reg_error;
    logic            done;
    logic            abs_csr_write;
    regno_t          abs_regno;
    logic [xlen-1:0] abs_data;
    logic [xlen-1:0] rd_data;

    d_ctl u_ctl (
        .clk        (clk),
        .rst_n      (rst_n),
        .eb         (eb),
        .trig       (trig),
        .pc_reg     (pc_reg),
        .pc_next    (pc_next),
        .ctrl       (ctrl),
        .csrs       (csrs),
        .dm_req     (dm_req),
        .debug      (debug),
        .halted     (halted),
        .step_en    (step_en),
        .reg_error  (reg_error),
        .done       (done),
        .dcsr_cause (dcsr_cause),
        .dpc_in     (dpc_in),
        .dpc_write  (dpc_write)
    );

    debug_csrs u_csrs (
        .clk           (clk),
        .rst_n         (rst_n),
        .dcsr_cause    (dcsr_cause),
        .dpc_in        (dpc_in),
        .dpc_write     (dpc_write),
        .abs_csr_write (abs_csr_write),
        .abs_regno     (abs_regno),
        .abs_data      (abs_data),
        .csrs          (csrs)
    );

    core_ctl_seq u_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .eb            (eb),
        .debug         (debug),
        .dm_req        (dm_req),
        .reg_error     (reg_error),
        .csrs          (csrs),
        .ctrl          (ctrl),
        .pc_reg        (pc_reg),
        .pc_next       (pc_next),
        .abs_csr_write (abs_csr_write),
        .abs_regno     (abs_regno),
        .abs_data      (abs_data),
        .rd_data       (rd_data)
    );

    assign pc = pc_reg;

    assign dm_rsp.halted     = halted;
    assign dm_rsp.done       = done;
    assign dm_rsp.exception  = reg_error;
    assign dm_rsp.haltresume = 1'b0;
    assign dm_rsp.data       = rd_data;

endmodule

// File: tests/debug_checker.sv
`timescale 1ns/1ps

module debug_checker import debug_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      debug,
    input  logic      dpc_write,
    input  logic      halted,
    input  ctrl_sig_t ctrl
);

    int unsigned fail_count = 0;

    // DPC is captured only as a running hart moves into the halted state.
    dpc_on_entry: assert property (@(posedge clk) disable iff (!rst_n)
        dpc_write |=> (ctrl.state == st_halted) && $past(ctrl.state == st_run))
    else begin
        $error("dpc_write asserted outside entry from the running state");
        fail_count++;
    end

    // Once resuming the hart is out of debug mode and halted stays low.
    resume_drops_halt: assert property (@(posedge clk) disable iff (!rst_n)
        (ctrl.state == st_resuming) |=> !halted && !$past(debug))
    else begin
        $error("debug or halted still high after the sequencer resumed");
        fail_count++;
    end

endmodule

bind d_ctl debug_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .debug     (debug),
    .dpc_write (dpc_write),
    .halted    (halted),
    .ctrl      (ctrl)
);

// File: tests/debug_tb.sv
`timescale 1ns/1ps

module debug_tb import debug_pkg::*; ();

    localparam int  clk_period     = 20;
    localparam int  num_tests      = 5;
    localparam time watchdog_limit = (num_tests * 200 + 1000) * clk_period;

    logic            clk;
    logic            rst_n;
    dm_req_t         dm_req;
    logic            trig;
    logic            eb;
    dm_rsp_t         dm_rsp;
    logic            debug;
    logic            halted;
    logic            step_en;
    logic [xlen-1:0] pc;

    // Reference model of the hart's debug state.
    seq_state_t      m_state;
    logic [xlen-1:0] m_pc;
    logic [xlen-1:0] m_dpc;
    logic [2:0]      m_cause;
    logic            m_step;
    logic            m_ebreakm;
    logic [xlen-1:0] m_gpr [32];

    integer          seed;
    int              errors;
    int              test_errors;
    int              tests_run;
    int              tests_failed;
    string           test_name;
    dm_rsp_t         last_rsp;

    debug_top UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .dm_req  (dm_req),
        .trig    (trig),
        .eb      (eb),
        .dm_rsp  (dm_rsp),
        .debug   (debug),
        .halted  (halted),
        .step_en (step_en),
        .pc      (pc)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_limit);
        $display("Watchdog expired at %0t before the tests completed", $time);
        $display("Test failures found");
        $finish;
    end

    function automatic logic [xlen-1:0] dcsr_image();
        return {4'd4, 12'd0, m_ebreakm, 6'd0, m_cause, 3'd0, m_step, 2'd0};
    endfunction

    function automatic logic regno_ok(input logic [15:0] regno);
        return ((regno >= 16'h1000) && (regno <= 16'h101F))
               || (regno == 16'h07B0) || (regno == 16'h07B1);
    endfunction

    function automatic logic [xlen-1:0] predicted_read(input logic [15:0] regno);
        if ((regno >= 16'h1000) && (regno <= 16'h101F)) begin
            return m_gpr[regno[4:0]];
        end else if (regno == 16'h07B0) begin
            return dcsr_image();
        end else if (regno == 16'h07B1) begin
            return m_dpc;
        end
        return '0;
    endfunction

    task automatic compare_value(input string what, input logic [xlen-1:0] exp,
                                 input logic [xlen-1:0] got);
        if (got !== exp) begin
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, got);
            test_errors++;
        end
    endtask

    // Called 2 ns after a rising edge with this cycle's inputs already driven.
    task automatic clock_cycle();
        logic            run;
        logic            exp_err;
        logic            exp_debug;
        logic            exp_halted;
        logic [2:0]      cause;
        logic [xlen-1:0] dpc_new;
        logic [15:0]     regno;
        #8;
        run     = m_state == st_run;
        regno   = dm_req.command.regno;
        cause   = 3'd0;
        dpc_new = m_pc + 32'd4;
        if (run && trig) begin
            cause   = cause_trigger;
            dpc_new = m_pc;
        end else if (run && eb && m_ebreakm) begin
            cause   = cause_ebreak;
            dpc_new = m_pc;
        end else if (run && dm_req.halt_req) begin
            cause   = cause_haltreq;
            dpc_new = eb ? m_pc : m_pc + 32'd4;
        end else if (run && m_step) begin
            cause   = cause_step;
        end
        exp_debug  = ((m_state == st_halted) || (m_state == st_abs_reg) || (cause != 3'd0))
                     && !dm_req.resume_req;
        exp_halted = (m_state == st_halted) || (m_state == st_abs_reg);
        exp_err    = (m_state == st_abs_reg) && (dm_req.command.cmdtype == 8'd0)
                     && dm_req.command.transfer && !regno_ok(regno);
        compare_value("debug", 32'(exp_debug), 32'(debug));
        compare_value("halted", 32'(exp_halted), 32'(halted));
        compare_value("rsp halted", 32'(exp_halted), 32'(dm_rsp.halted));
        compare_value("step_en", 32'(m_step), 32'(step_en));
        compare_value("haltresume", 32'd0, 32'(dm_rsp.haltresume));
        compare_value("pc", m_pc, pc);
        compare_value("done", 32'(m_state == st_abs_reg), 32'(dm_rsp.done));
        compare_value("exception", 32'(exp_err), 32'(dm_rsp.exception));
        if ((m_state == st_abs_reg) && !exp_err && !dm_req.command.write) begin
            compare_value("read data", predicted_read(regno), dm_rsp.data);
        end
        last_rsp = dm_rsp;
        @(posedge clk);
        case (m_state)
            st_run: begin
                if (cause != 3'd0) begin
                    m_state = st_halted;
                    m_cause = cause;
                    m_dpc   = dpc_new;
                end else begin
                    m_pc = m_pc + 32'd4;
                end
            end
            st_halted: begin
                if (dm_req.resume_req) begin
                    m_state = st_resuming;
                end else if (dm_req.exec) begin
                    m_state = st_abs_reg;
                end
            end
            st_abs_reg: begin
                if ((dm_req.command.cmdtype == 8'd0) && dm_req.command.transfer
                    && dm_req.command.write && !exp_err) begin
                    if ((regno >= 16'h1000) && (regno <= 16'h101F)) begin
                        if (regno[4:0] != 5'd0) begin
                            m_gpr[regno[4:0]] = dm_req.data;
                        end
                    end else if (regno == 16'h07B0) begin
                        m_step    = dm_req.data[2];
                        m_ebreakm = dm_req.data[15];
                    end else begin
                        m_dpc = dm_req.data;
                    end
                end
                m_state = st_halted;
            end
            default: begin
                m_pc    = m_dpc;
                m_state = st_run;
            end
        endcase
        #2;
        dm_req.halt_req   = 1'b0;
        dm_req.resume_req = 1'b0;
        dm_req.exec       = 1'b0;
        trig              = 1'b0;
        eb                = 1'b0;
    endtask

    task automatic run_cycles(input int n);
        repeat (n) clock_cycle();
    endtask

    task automatic exec_cmd(input logic is_write, input logic [15:0] regno,
                            input logic [xlen-1:0] data, output dm_rsp_t rsp);
        dm_req.command.cmdtype  = 8'd0;
        dm_req.command.transfer = 1'b1;
        dm_req.command.write    = is_write;
        dm_req.command.regno    = regno;
        dm_req.data             = data;
        dm_req.exec             = 1'b1;
        clock_cycle();
        if (m_state != st_abs_reg) begin
            $display("%s: command issued while the hart was not halted", test_name);
            test_errors++;
        end
        clock_cycle();
        rsp = last_rsp;
    endtask

    task automatic read_reg(input logic [15:0] regno, output logic [xlen-1:0] data);
        dm_rsp_t rsp;
        exec_cmd(1'b0, regno, '0, rsp);
        data = rsp.data;
    endtask

    task automatic write_reg(input logic [15:0] regno, input logic [xlen-1:0] data);
        dm_rsp_t rsp;
        exec_cmd(1'b1, regno, data, rsp);
    endtask

    task automatic halt_now();
        dm_req.halt_req = 1'b1;
        clock_cycle();
    endtask

    task automatic resume_now();
        dm_req.resume_req = 1'b1;
        clock_cycle();
        clock_cycle();
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, test_errors);
            tests_failed++;
        end
        errors      = errors + test_errors;
        test_errors = 0;
    endtask

    initial begin
        logic [xlen-1:0] rd;
        logic [xlen-1:0] halt_pc;
        logic [15:0]     regno;
        int              idx;
        dm_rsp_t         rsp;
        seed         = 32'h22bf_e86d;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        dm_req       = '0;
        trig         = 1'b0;
        eb           = 1'b0;
        m_state      = st_run;
        m_pc         = '0;
        m_dpc        = '0;
        m_cause      = 3'd0;
        m_step       = 1'b0;
        m_ebreakm    = 1'b0;
        for (int i = 0; i < 32; i++) begin
            m_gpr[i] = 32'(i) * 32'h0101_0101;
        end
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        test_name = "halt_request";
        run_cycles(1 + int'($unsigned($random(seed)) % 20));
        halt_pc = m_pc;
        halt_now();
        compare_value("halted after request", 32'd1, 32'(halted));
        read_reg(csr_dcsr, rd);
        compare_value("dcsr.cause", 32'(cause_haltreq), 32'(rd[8:6]));
        read_reg(csr_dpc, rd);
        compare_value("dpc", halt_pc + 32'd4, rd);
        finish_test();

        test_name = "trigger_ebreak";
        write_reg(csr_dcsr, 32'h0000_8000);
        resume_now();
        run_cycles(2 + int'($unsigned($random(seed)) % 8));
        halt_pc = m_pc;
        trig    = 1'b1;
        eb      = 1'b1;
        clock_cycle();
        read_reg(csr_dcsr, rd);
        compare_value("dcsr.cause", 32'(cause_trigger), 32'(rd[8:6]));
        read_reg(csr_dpc, rd);
        compare_value("dpc", halt_pc, rd);
        // With ebreakm clear an ebreak just retires.
        write_reg(csr_dcsr, 32'h0000_0000);
        resume_now();
        run_cycles(2);
        eb = 1'b1;
        clock_cycle();
        compare_value("halted after plain ebreak", 32'd0, 32'(halted));
        run_cycles(1);
        halt_now();
        write_reg(csr_dcsr, 32'h0000_8000);
        resume_now();
        run_cycles(1 + int'($unsigned($random(seed)) % 5));
        halt_pc = m_pc;
        eb      = 1'b1;
        clock_cycle();
        read_reg(csr_dcsr, rd);
        compare_value("dcsr.cause", 32'(cause_ebreak), 32'(rd[8:6]));
        read_reg(csr_dpc, rd);
        compare_value("dpc", halt_pc, rd);
        finish_test();

        test_name = "single_step";
        write_reg(csr_dcsr, 32'h0000_0004);
        halt_pc           = m_dpc;
        dm_req.resume_req = 1'b1;
        clock_cycle();
        compare_value("halted while resuming", 32'd0, 32'(halted));
        run_cycles(2);
        compare_value("halted after one step", 32'd1, 32'(halted));
        read_reg(csr_dcsr, rd);
        compare_value("dcsr.cause", 32'(cause_step), 32'(rd[8:6]));
        read_reg(csr_dpc, rd);
        compare_value("dpc", halt_pc + 32'd4, rd);
        write_reg(csr_dcsr, 32'h0000_0000);
        finish_test();

        test_name = "gpr_access";
        repeat (16) begin
            idx   = int'($unsigned($random(seed)) % 32);
            regno = 16'h1000 + 16'(idx);
            if ($random(seed) & 1) begin
                write_reg(regno, $random(seed));
            end else begin
                read_reg(regno, rd);
                compare_value("gpr read", m_gpr[idx], rd);
            end
        end
        write_reg(16'h1000, $random(seed));
        read_reg(16'h1000, rd);
        compare_value("x0", 32'd0, rd);
        finish_test();

        test_name = "invalid_regno";
        for (int k = 0; k < 4; k++) begin
            case (k)
                0: regno = 16'h07B2;
                1: regno = 16'h1020;
                2: regno = 16'h0300;
                default: regno = 16'h0FFF;
            endcase
            exec_cmd(k[0] == 1'b0, regno, $random(seed), rsp);
            compare_value("exception", 32'd1, 32'(rsp.exception));
            compare_value("done with exception", 32'd1, 32'(rsp.done));
        end
        read_reg(csr_dcsr, rd);
        compare_value("dcsr unchanged", dcsr_image(), rd);
        read_reg(csr_dpc, rd);
        compare_value("dpc unchanged", m_dpc, rd);
        for (int i = 1; i < 32; i++) begin
            read_reg(16'h1000 + 16'(i), rd);
            compare_value("gpr unchanged", m_gpr[i], rd);
        end
        finish_test();

        $display("Summary: %0d tests run, %0d failed, %0d mismatches, %0d assertion failures",
                 tests_run, tests_failed, errors, UUT.u_ctl.u_checker.fail_count);
        if ((errors == 0) && (UUT.u_ctl.u_checker.fail_count == 0)) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: list.f
source/debug_pkg.sv
source/d_ctl.sv
source/debug_csrs.sv
source/core_ctl_seq.sv
source/debug_top.sv
tests/debug_checker.sv
tests/debug_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := debug_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
SIM_ARGS  := +verilator+error+limit+1000
FAIL_MSG  := Test failures found
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) > $(SIM_LOG) 2>&1; status=$$?; \
	cat $(SIM_LOG); \
	if grep -q "$(FAIL_MSG)" $(SIM_LOG) || [ $$status -ne 0 ]; then \
		echo "Simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
